//--- build.f
src/div_pkg.sv
src/div_apb_regs.sv
src/div_req_fifo.sv
src/div_operand_prep.sv
src/div_serial.sv
src/div_top.sv
tb/tb_div_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the divider testbench with Verilator, from the project root
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_div_top -f build.f -o sim_div
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_div > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- src/div_apb_regs.sv
////////////////////
// APB slave with zero wait states and full-word writes only
// CMD write while full or RESULT read with no result gives pslverr
// pwdata[1:0] of a CMD write is the opcode
////////////////////

`timescale 1ns/100ps

module div_apb_regs import div_pkg::*; #(
  parameter int WIDTH = DIV_WIDTH,
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic                         Clk_CI,
  input  logic                         Rst_RBI,
  // APB slave port
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [7:0]                   paddr,
  input  logic [WIDTH-1:0]             pwdata,
  output logic [WIDTH-1:0]             prdata,
  output logic                         pready,
  output logic                         pslverr,
  // request FIFO side
  input  logic                         full,
  input  logic [$clog2(DEPTH+1)-1:0]   level,
  output logic                         push,
  output logic [WIDTH-1:0]             push_a,
  output logic [WIDTH-1:0]             push_b,
  output div_op_e                      push_op,
  // result side
  input  logic                         out_vld,
  input  logic [WIDTH-1:0]             res,
  output logic                         out_rdy
);

  localparam int LVL_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] op_a_q;
  logic [WIDTH-1:0] op_b_q;
  logic             wr_acc;
  logic             rd_acc;
  logic             cmd_wr;
  logic             res_rd;

  ////////////////////
  // access decode
  ////////////////////

  // access phase completes at once
  assign pready = 1'b1;
  assign wr_acc = psel & penable & pwrite;
  assign rd_acc = psel & penable & ~pwrite;
  assign cmd_wr = wr_acc & (paddr == ADDR_CMD);
  assign res_rd = rd_acc & (paddr == ADDR_RESULT);

  // queue request only when there is room
  assign push    = cmd_wr & ~full;
  assign push_a  = op_a_q;
  assign push_b  = op_b_q;
  assign push_op = div_op_e'(pwdata[1:0]);

  // result pops on the read access itself
  assign out_rdy = res_rd;
  assign pslverr = (cmd_wr & full) | (res_rd & ~out_vld);

  // operand registers
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin : p_operands
    if (!Rst_RBI) begin
      op_a_q <= '0;
      op_b_q <= '0;
    end else if (wr_acc) begin
      if (paddr == ADDR_OP_A) op_a_q <= pwdata;
      if (paddr == ADDR_OP_B) op_b_q <= pwdata;
    end
  end

  ////////////////////
  // read mux
  ////////////////////
  always_comb begin : p_rdata
    prdata = '0;
    case (paddr)
      ADDR_OP_A:   prdata = op_a_q;
      ADDR_OP_B:   prdata = op_b_q;
      // zero when nothing is pending
      ADDR_RESULT: prdata = out_vld ? res : '0;
      ADDR_STATUS: begin
        prdata[STAT_VALID_BIT]          = out_vld;
        prdata[STAT_FULL_BIT]           = full;
        prdata[STAT_LEVEL_LSB +: LVL_W] = level;
      end
      default: prdata = '0;
    endcase
  end

  // FIFO must never be overrun by a command
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) push |-> (level < LVL_W'(DEPTH)))
    else $error("command pushed while the FIFO level is at DEPTH");

endmodule

//--- src/div_operand_prep.sv
////////////////////
// hands the head request to the divider when it is idle
// B goes out as magnitude normalised so its MSB is set
////////////////////

`timescale 1ns/100ps

module div_operand_prep import div_pkg::*; #(
  parameter int WIDTH = DIV_WIDTH
) (
  input  logic                       Clk_CI,
  input  logic                       Rst_RBI,
  input  logic                       empty,
  input  logic [WIDTH-1:0]           head_a,
  input  logic [WIDTH-1:0]           head_b,
  input  div_op_e                    head_op,
  input  logic                       ready,
  output logic                       pop,
  output logic                       in_vld,
  output logic [WIDTH-1:0]           op_a,
  output logic [WIDTH-1:0]           op_b,
  output logic [$clog2(WIDTH+1)-1:0] op_b_shift,
  output logic                       op_b_zero,
  output logic                       op_b_sign,
  output div_op_e                    opcode
);

  localparam int LW = $clog2(WIDTH + 1);

  logic [WIDTH-1:0] b_mag;
  logic [LW-1:0]    b_lz;

  // start and consume in the same cycle
  assign in_vld = ready & ~empty;
  assign pop    = in_vld;

  assign op_a   = head_a;
  assign opcode = head_op;

  // unsigned ops never see a negative B
  assign op_b_sign = head_op[0] & head_b[WIDTH-1];
  assign b_mag     = op_b_sign ? (~head_b + 1'b1) : head_b;
  assign op_b_zero = ~|head_b;

  // the highest set bit sets the count and zero gives WIDTH
  always_comb begin : p_lzc
    b_lz = LW'(WIDTH);
    for (int i = 0; i < WIDTH; i++) begin
      if (b_mag[i]) b_lz = LW'(WIDTH - 1 - i);
    end
  end

  assign op_b_shift = b_lz;
  assign op_b       = b_mag << b_lz;

  // a nonzero B reaches the divider with its MSB set
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
                   in_vld && !op_b_zero |-> op_b[WIDTH-1])
    else $error("B not normalised at divider start");

endmodule

//--- src/div_pkg.sv
////////////////////
// shared constants and opcode encoding for the divider peripheral
// APB offsets are byte addresses, only full-word accesses are decoded
////////////////////

package div_pkg;

  // default operand width, top level passes it down as WIDTH
  localparam int DIV_WIDTH = 32;

  // default request FIFO depth, passed down as DEPTH
  localparam int FIFO_DEPTH = 4;

  // bit 0 selects signed, bit 1 selects remainder
  typedef enum logic [1:0] {
    OP_DIVU = 2'd0,
    OP_DIV  = 2'd1,
    OP_REMU = 2'd2,
    OP_REM  = 2'd3
  } div_op_e;

  ////////////////////
  // APB register map
  ////////////////////
  localparam logic [7:0] ADDR_OP_A   = 8'h00;
  localparam logic [7:0] ADDR_OP_B   = 8'h04;
  localparam logic [7:0] ADDR_CMD    = 8'h08;
  localparam logic [7:0] ADDR_RESULT = 8'h0C;
  localparam logic [7:0] ADDR_STATUS = 8'h10;

  // status fields
  localparam int STAT_VALID_BIT = 0;
  localparam int STAT_FULL_BIT  = 1;
  // fill level starts here, width is clog2(DEPTH+1)
  localparam int STAT_LEVEL_LSB = 8;

endpackage

//--- src/div_req_fifo.sv
////////////////////
// request FIFO, head is read combinationally
// pushed word shows at the head one cycle later
////////////////////

`timescale 1ns/100ps

module div_req_fifo import div_pkg::*; #(
  parameter int WIDTH = DIV_WIDTH,
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic                       Clk_CI,
  input  logic                       Rst_RBI,
  input  logic                       push,
  input  logic [WIDTH-1:0]           push_a,
  input  logic [WIDTH-1:0]           push_b,
  input  div_op_e                    push_op,
  input  logic                       pop,
  output logic [WIDTH-1:0]           head_a,
  output logic [WIDTH-1:0]           head_b,
  output div_op_e                    head_op,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] level
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LVL_W = $clog2(DEPTH + 1);

  // storage, one entry per queued request
  logic [WIDTH-1:0] mem_a  [DEPTH];
  logic [WIDTH-1:0] mem_b  [DEPTH];
  div_op_e          mem_op [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [LVL_W-1:0] count_q;

  assign head_a  = mem_a[rd_ptr_q];
  assign head_b  = mem_b[rd_ptr_q];
  assign head_op = mem_op[rd_ptr_q];
  assign full    = (count_q == LVL_W'(DEPTH));
  assign empty   = (count_q == '0);
  assign level   = count_q;

  // pointers wrap at DEPTH, any depth works
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin : p_ptrs
    if (!Rst_RBI) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      // simultaneous push and pop keeps the count
      if (push && !pop)      count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge Clk_CI) begin : p_mem
    if (push) begin
      mem_a[wr_ptr_q]  <= push_a;
      mem_b[wr_ptr_q]  <= push_b;
      mem_op[wr_ptr_q] <= push_op;
    end
  end

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) pop |-> !empty)
    else $error("pop from empty request FIFO");
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) push |-> !full)
    else $error("push into full request FIFO");

endmodule

//--- src/div_serial.sv
////////////////////
// restoring serial divider on magnitudes with the sign fixed at the output
// takes op_b_shift+1 divide cycles and holds the result until out_rdy
// div by zero and MIN/-1 follow the RISC-V results
////////////////////

`timescale 1ns/100ps

module div_serial import div_pkg::*; #(
  parameter int WIDTH     = DIV_WIDTH,
  parameter int LOG_WIDTH = 6
) (
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  // request side
  input  logic [WIDTH-1:0]     op_a,
  input  logic [WIDTH-1:0]     op_b,
  input  logic [LOG_WIDTH-1:0] op_b_shift,
  input  logic                 op_b_zero,
  input  logic                 op_b_sign,
  input  div_op_e              opcode,
  input  logic                 in_vld,
  output logic                 ready,
  // result side
  input  logic                 out_rdy,
  output logic                 out_vld,
  output logic [WIDTH-1:0]     res
);

  typedef enum logic [1:0] {IDLE, DIVIDE, FINISH} state_e;

  state_e state_q;
  state_e state_d;

  logic [WIDTH-1:0]     a_q;
  logic [WIDTH-1:0]     b_q;
  // quotient bits enter at the top MSB first
  logic [WIDTH-1:0]     quot_q;
  logic [WIDTH-1:0]     quot_rev;
  logic [LOG_WIDTH-1:0] cnt_q;
  logic                 rem_sel_q;
  logic                 res_inv_q;

  logic                 load;
  logic                 a_sign;
  logic [WIDTH-1:0]     a_mag;
  logic                 a_ge_b;
  logic [WIDTH-1:0]     out_mux;

  ////////////////////
  // datapath
  ////////////////////

  assign load   = (state_q == IDLE) & in_vld;
  assign a_sign = opcode[0] & op_a[WIDTH-1];
  // MIN stays MIN and reads as an unsigned magnitude
  assign a_mag  = a_sign ? (~op_a + 1'b1) : op_a;
  assign a_ge_b = (a_q >= b_q);

  always_comb begin : p_reverse
    for (int i = 0; i < WIDTH; i++) begin
      quot_rev[i] = quot_q[WIDTH-1-i];
    end
  end

  assign out_mux = rem_sel_q ? a_q : quot_rev;
  assign res     = res_inv_q ? (~out_mux + 1'b1) : out_mux;

  always_ff @(posedge Clk_CI) begin : p_data
    if (load) begin
      a_q       <= a_mag;
      b_q       <= op_b;
      quot_q    <= '0;
      rem_sel_q <= opcode[1];
      // remainder follows A and quotient follows A^B unless B is zero
      res_inv_q <= opcode[1] ? a_sign : ((a_sign ^ op_b_sign) & ~op_b_zero);
    end else if (state_q == DIVIDE) begin
      if (a_ge_b) a_q <= a_q - b_q;
      b_q    <= b_q >> 1;
      quot_q <= {a_ge_b, quot_q[WIDTH-1:1]};
    end
  end

  ////////////////////
  // FSM
  ////////////////////

  assign ready   = (state_q == IDLE);
  assign out_vld = (state_q == FINISH);

  always_comb begin : p_fsm
    state_d = state_q;
    case (state_q)
      IDLE:    if (in_vld) state_d = DIVIDE;
      // last divide cycle runs with cnt at zero
      DIVIDE:  if (cnt_q == '0) state_d = FINISH;
      FINISH:  if (out_rdy) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin : p_ctrl
    if (!Rst_RBI) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (load) cnt_q <= op_b_shift;
      else if ((state_q == DIVIDE) && (cnt_q != '0)) cnt_q <= cnt_q - 1'b1;
    end
  end

  // finished result waits unchanged for the host
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
                   out_vld && !out_rdy |=> out_vld && $stable(res))
    else $error("result dropped or changed before readback");
  assert property (@(posedge Clk_CI) LOG_WIDTH == $clog2(WIDTH + 1))
    else $error("LOG_WIDTH must be clog2(WIDTH+1)");

endmodule

//--- src/div_top.sv
////////////////////
// divider peripheral, APB slave with queued requests
// one finished result held, divider stalls until it is read
////////////////////

`timescale 1ns/100ps

module div_top import div_pkg::*; #(
  parameter int WIDTH = DIV_WIDTH,
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic             Clk_CI,
  input  logic             Rst_RBI,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [7:0]       paddr,
  input  logic [WIDTH-1:0] pwdata,
  output logic [WIDTH-1:0] prdata,
  output logic             pready,
  output logic             pslverr
);

  // counter must hold 0..WIDTH
  localparam int LOG_WIDTH = $clog2(WIDTH + 1);
  localparam int LVL_W     = $clog2(DEPTH + 1);

  // regs to FIFO
  logic             push;
  logic [WIDTH-1:0] push_a;
  logic [WIDTH-1:0] push_b;
  div_op_e          push_op;
  logic             full;
  logic [LVL_W-1:0] level;

  // FIFO to prep
  logic             empty;
  logic             pop;
  logic [WIDTH-1:0] head_a;
  logic [WIDTH-1:0] head_b;
  div_op_e          head_op;

  // prep to divider
  logic                 ready;
  logic                 in_vld;
  logic [WIDTH-1:0]     op_a;
  logic [WIDTH-1:0]     op_b;
  logic [LOG_WIDTH-1:0] op_b_shift;
  logic                 op_b_zero;
  logic                 op_b_sign;
  div_op_e              opcode;

  // divider to regs
  logic             out_vld;
  logic             out_rdy;
  logic [WIDTH-1:0] res;

  div_apb_regs #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_regs (
    .Clk_CI, .Rst_RBI,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .full, .level, .push, .push_a, .push_b, .push_op,
    .out_vld, .res, .out_rdy
  );

  div_req_fifo #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_fifo (
    .Clk_CI, .Rst_RBI,
    .push, .push_a, .push_b, .push_op, .pop,
    .head_a, .head_b, .head_op, .full, .empty, .level
  );

  div_operand_prep #(.WIDTH(WIDTH)) u_prep (
    .Clk_CI, .Rst_RBI,
    .empty, .head_a, .head_b, .head_op, .ready,
    .pop, .in_vld, .op_a, .op_b, .op_b_shift, .op_b_zero, .op_b_sign, .opcode
  );

  div_serial #(.WIDTH(WIDTH), .LOG_WIDTH(LOG_WIDTH)) u_div (
    .Clk_CI, .Rst_RBI,
    .op_a, .op_b, .op_b_shift, .op_b_zero, .op_b_sign, .opcode,
    .in_vld, .ready, .out_rdy, .out_vld, .res
  );

endmodule

//--- tb/div_cases.txt
# name kind opcode(0 divu 1 div 2 remu 3 rem) A B expected, A B expected in hex
# kinds: single, queue, over (expected = pslverr), drain, empty (expected = pslverr)
divu_basic single 0 00000064 00000007 0000000e
remu_basic single 2 00000064 00000007 00000002
divu_max single 0 ffffffff 00000010 0fffffff
remu_big single 2 ffffffff 12345678 0123456f
remu_top_b single 2 7fffffff 80000000 7fffffff
divu_rand single 0 deadbeef 00001234 000c3ba5
remu_rand single 2 deadbeef 00001234 0000076b
div_pos_pos single 1 00000007 00000002 00000003
div_neg_pos single 1 fffffff9 00000002 fffffffd
div_pos_neg single 1 00000007 fffffffe fffffffd
div_neg_neg single 1 fffffff9 fffffffe 00000003
rem_pos_pos single 3 00000007 00000002 00000001
rem_neg_pos single 3 fffffff9 00000002 ffffffff
rem_pos_neg single 3 00000007 fffffffe 00000001
rem_neg_neg single 3 fffffff9 fffffffe ffffffff
divu_by_zero single 0 12345678 00000000 ffffffff
remu_by_zero single 2 12345678 00000000 12345678
div_by_zero single 1 fffffffb 00000000 ffffffff
rem_by_zero single 3 fffffffb 00000000 fffffffb
div_min_m1 single 1 80000000 ffffffff 80000000
rem_min_m1 single 3 80000000 ffffffff 00000000
q0_divu queue 0 000003e8 0000000a 00000064
q1_rem queue 3 ffffff9c 00000007 fffffffe
q2_div queue 1 ffffff9c 00000007 fffffff2
q3_remu queue 2 0000ffff 00000100 000000ff
q4_divu queue 0 ffffffff 00000001 ffffffff
q5_over over 0 00000001 00000001 00000001
drain_all drain 0 00000000 00000000 00000000
read_empty empty 0 00000000 00000000 00000001

//--- tb/tb_div_top.sv
////////////////////
// testbench for div_top with cases from tb/div_cases.txt
// run from the project root with the package default WIDTH and DEPTH
////////////////////

`timescale 1ns/100ps

module tb_div_top import div_pkg::*; ();

  localparam int WIDTH = DIV_WIDTH;
  localparam int DEPTH = FIFO_DEPTH;

  logic             Clk_CI;
  logic             Rst_RBI;
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [7:0]       paddr;
  logic [WIDTH-1:0] pwdata;
  logic [WIDTH-1:0] prdata;
  logic             pready;
  logic             pslverr;

  // case table with one entry per data line
  string            case_name [$];
  string            case_kind [$];
  int               case_op   [$];
  logic [WIDTH-1:0] case_a    [$];
  logic [WIDTH-1:0] case_b    [$];
  logic [WIDTH-1:0] case_exp  [$];

  // results owed by queued commands in command order
  string            pend_name [$];
  logic [WIDTH-1:0] pend_exp  [$];

  int   cycles = 0;
  int   cycle_limit;
  logic polling;

  div_top #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_dut (
    .Clk_CI, .Rst_RBI,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  // 4 ns period
  always #2 Clk_CI = ~Clk_CI;

  ////////////////////
  // checks
  ////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_res(input string name, input logic [WIDTH-1:0] exp,
                           input logic [WIDTH-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("FAIL %s pslverr: expected %b, actual %b", name, exp, act));
    end
  endtask

  // opcode column must be one of the four encodings
  task automatic check_op(input string name, input int exp, input div_op_e act);
    if (int'(act) != exp) begin
      stop_run($sformatf("FAIL %s opcode: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  ////////////////////
  // APB master
  ////////////////////

  // random idle gap then setup phase and one access cycle
  task automatic apb_xfer(input logic wr, input logic [7:0] addr,
                          input logic [WIDTH-1:0] wdata,
                          output logic [WIDTH-1:0] rdata, output logic err);
    int gap;
    gap = $urandom % 3;
    repeat (gap) @(posedge Clk_CI);
    @(posedge Clk_CI);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge Clk_CI);
    penable <= 1'b1;
    // response settles mid access cycle
    @(negedge Clk_CI);
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) begin
      stop_run("APB access did not complete, pready was low in the access cycle");
    end
    @(posedge Clk_CI);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // operands then command with opcode in the low bits
  task automatic send_request(input string name, input logic [WIDTH-1:0] a,
                              input logic [WIDTH-1:0] b, input div_op_e op,
                              input logic exp_err);
    logic [WIDTH-1:0] rd;
    logic             err;
    apb_xfer(1'b1, ADDR_OP_A, a, rd, err);
    check_err({name, "_opa"}, 1'b0, err);
    apb_xfer(1'b1, ADDR_OP_B, b, rd, err);
    check_err({name, "_opb"}, 1'b0, err);
    apb_xfer(1'b1, ADDR_CMD, WIDTH'(op), rd, err);
    check_err({name, "_cmd"}, exp_err, err);
  endtask

  // poll STATUS until a result is held
  task automatic wait_result();
    logic [WIDTH-1:0] st;
    logic             err;
    polling = 1'b1;
    st      = '0;
    while (!st[STAT_VALID_BIT]) begin
      apb_xfer(1'b0, ADDR_STATUS, '0, st, err);
      check_err("status_poll", 1'b0, err);
    end
    polling = 1'b0;
  endtask

  task automatic read_result(input string name, input logic [WIDTH-1:0] exp);
    logic [WIDTH-1:0] rd;
    logic             err;
    wait_result();
    apb_xfer(1'b0, ADDR_RESULT, '0, rd, err);
    check_err(name, 1'b0, err);
    check_res(name, exp, rd);
  endtask

  ////////////////////
  // cases file
  ////////////////////

  task automatic load_cases();
    int               fd;
    int               n;
    int               op;
    string            line;
    string            nm;
    string            kd;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] e;
    fd = $fopen("tb/div_cases.txt", "r");
    if (fd == 0) begin
      stop_run("could not open tb/div_cases.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0) break;
      // skip blank and comment lines
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%s %s %d %h %h %h", nm, kd, op, a, b, e);
      if (n != 6) begin
        stop_run($sformatf("malformed line in cases file: %s", line));
      end
      case_name.push_back(nm);
      case_kind.push_back(kd);
      case_op.push_back(op);
      case_a.push_back(a);
      case_b.push_back(b);
      case_exp.push_back(e);
    end
    $fclose(fd);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : p_main
    logic [WIDTH-1:0] rd;
    logic             err;
    div_op_e          op;
    void'($urandom(87));
    Clk_CI  = 1'b0;
    Rst_RBI = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    polling = 1'b0;
    cycle_limit = 0;
    load_cases();
    // worst case divide plus a few APB transfers per line
    cycle_limit = case_name.size() * (WIDTH + 40);
    repeat (4) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;

    foreach (case_name[i]) begin
      op = div_op_e'(case_op[i][1:0]);
      case (case_kind[i])
        "single": begin
          check_op(case_name[i], case_op[i], op);
          send_request(case_name[i], case_a[i], case_b[i], op, 1'b0);
          read_result(case_name[i], case_exp[i]);
        end
        // queued without reading and checked by a later drain
        "queue": begin
          check_op(case_name[i], case_op[i], op);
          send_request(case_name[i], case_a[i], case_b[i], op, 1'b0);
          pend_name.push_back(case_name[i]);
          pend_exp.push_back(case_exp[i]);
        end
        // divider stalled with FIFO full so the expected column is pslverr
        "over": begin
          check_op(case_name[i], case_op[i], op);
          send_request(case_name[i], case_a[i], case_b[i], op, case_exp[i][0]);
        end
        "drain": begin
          while (pend_exp.size() > 0) begin
            read_result(pend_name.pop_front(), pend_exp.pop_front());
          end
        end
        // nothing held so STATUS must read all zero
        "empty": begin
          apb_xfer(1'b0, ADDR_RESULT, '0, rd, err);
          check_err(case_name[i], case_exp[i][0], err);
          apb_xfer(1'b0, ADDR_STATUS, '0, rd, err);
          check_err({case_name[i], "_status"}, 1'b0, err);
          check_res({case_name[i], "_status"}, '0, rd);
        end
        default: begin
          stop_run($sformatf("unknown case kind %s on line %s", case_kind[i], case_name[i]));
        end
      endcase
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

  // cycle budget from the number of cases
  always @(posedge Clk_CI) begin : p_timeout
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      if (polling) begin
        stop_run("timeout: result never became valid");
      end else begin
        stop_run("timeout: run did not finish within the cycle limit");
      end
    end
  end

endmodule
